// File: hw/frame_matcher.sv
// compares the first FRAME_WORDS words of each frame; no ready, every valid word is taken
`timescale 1ns/1ps
`include "rvvi_host_config.svh"

module frame_matcher import rvvi_host_pkg::*; #(
  parameter logic [`FRAME_WORDS*`RX_WORD_W-1:0] COMPARE = '0
) (
  input  logic     CPUCLK,
  input  logic     bus_struct_reset,
  input  rx_word_t rx_data,
  input  rx_keep_t rx_keep,
  input  logic     rx_valid,
  input  logic     rx_last,
  output logic     match
);

  // index of the word that completes the compared header
  localparam word_idx_t last_idx = word_idx_t'(`FRAME_WORDS - 1);

  //////////////////////////////////////////////////
  // position and running compare
  //////////////////////////////////////////////////

  word_idx_t word_idx;     // position of the incoming word
  logic      still_equal;  // every compared word so far matched
  rx_word_t  cmp_word;     // string word for this position
  logic      in_window;    // word is one of the compared ones
  logic      word_ok;
  logic      run_equal;

  assign in_window = (word_idx < word_idx_t'(`FRAME_WORDS));

  // pick the string slice for the current position
  always_comb begin
    cmp_word = '0;
    for (int i = 0; i < `FRAME_WORDS; i++) begin
      if (word_idx == word_idx_t'(i)) begin
        cmp_word = COMPARE[i*`RX_WORD_W +: `RX_WORD_W];
      end
    end
  end

  // words past the header are payload and always pass
  assign word_ok   = !in_window || ((rx_data == cmp_word) && (&rx_keep));
  assign run_equal = still_equal & word_ok;

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      word_idx    <= '0;
      still_equal <= 1'b1;
    end else if (rx_valid) begin
      if (rx_last) begin
        // next word opens a fresh frame
        word_idx    <= '0;
        still_equal <= 1'b1;
      end else begin
        if (in_window) begin
          word_idx <= word_idx + 1'b1;  // saturates at FRAME_WORDS
        end
        still_equal <= run_equal;
      end
    end
  end

  //////////////////////////////////////////////////
  // match pulse
  //////////////////////////////////////////////////

  // one cycle after the accepted last word; short frames never reach last_idx
  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      match <= 1'b0;
    end else begin
      match <= rx_valid & rx_last & run_equal & (word_idx >= last_idx);
    end
  end

endmodule

// File: hw/request_tracker.sv
// counts slow-down requests seen during a window; counter holds at all ones instead of wrapping
`timescale 1ns/1ps

module request_tracker import rvvi_host_pkg::*; (
  input  logic CPUCLK,
  input  logic bus_struct_reset,
  input  logic slow_request,
  input  logic stalling,
  input  logic window_end,
  output logic request_pending
);

  logic           did_request;    // a request was seen since the last window end
  pending_count_t pending_count;  // windows still owed to the host
  logic           count_up;
  logic           count_down;

  //////////////////////////////////////////////////
  // did-request flag
  //////////////////////////////////////////////////

  // the request that opened a window is already paid for by that window
  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      did_request <= 1'b0;
    end else if (window_end) begin
      did_request <= 1'b0;  // clear wins over a same-cycle set
    end else if (slow_request) begin
      did_request <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // pending up/down counter
  //////////////////////////////////////////////////

  // mid-window request earns one more window
  assign count_up = slow_request & stalling & ~(&pending_count);

  // a window that closes with no fresh request used up one owed window
  assign count_down = window_end & ~did_request & (pending_count != '0);

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      pending_count <= '0;
    end else begin
      case ({count_up, count_down})
        2'b10:   pending_count <= pending_count + 1'b1;
        2'b01:   pending_count <= pending_count - 1'b1;
        default: pending_count <= pending_count;  // both or neither cancel out
      endcase
    end
  end

  assign request_pending = (pending_count != '0);  // keeps the sequencer re-arming

endmodule

// File: hw/rvvi_host_pkg.sv
// shared types, all widths come from rvvi_host_config.svh; word index saturates at FRAME_WORDS
`include "rvvi_host_config.svh"

package rvvi_host_pkg;

  //////////////////////////////////////////////////
  // receive side
  //////////////////////////////////////////////////

  typedef logic [`RX_WORD_W-1:0] rx_word_t;  // one mac receive word
  typedef logic [`RX_KEEP_W-1:0] rx_keep_t;  // byte keep for rx_word_t

  // counts 0 .. FRAME_WORDS, never wraps inside a long frame
  typedef logic [$clog2(`FRAME_WORDS+1)-1:0] word_idx_t;

  //////////////////////////////////////////////////
  // slow-down control
  //////////////////////////////////////////////////

  // idle until a request, armed until the packetizer stalls, then stalling
  typedef enum logic [1:0] {
    slow_idle     = 2'd0,
    slow_armed    = 2'd1,
    slow_stalling = 2'd2
  } slow_state_t;

  typedef logic [`STALL_CNT_W-1:0]   stall_count_t;    // cycles spent in the window
  typedef logic [`PENDING_CNT_W-1:0] pending_count_t;  // extra windows owed

endpackage

// File: hw/rvvi_host_top.sv
// host control path only; receive stream is never back-pressured, rvvi_stall comes from the packetizer
`timescale 1ns/1ps
`include "rvvi_host_config.svh"

module rvvi_host_top import rvvi_host_pkg::*; (
  input  logic     CPUCLK,
  input  logic     bus_struct_reset,
  input  rx_word_t rx_data,
  input  rx_keep_t rx_keep,
  input  logic     rx_valid,
  input  logic     rx_last,
  input  logic     rvvi_stall,
  output logic     ila_trigger,
  output logic     host_stall,
  output logic     external_stall
);

  logic slow_request;     // slow-down frame seen
  logic request_pending;  // extra windows still owed
  logic stalling;
  logic window_end;

  //////////////////////////////////////////////////
  // frame matchers
  //////////////////////////////////////////////////

  frame_matcher #(.COMPARE(`TRIGGER_STRING)) u_trigger_match (
    .CPUCLK,
    .bus_struct_reset,
    .rx_data,
    .rx_keep,
    .rx_valid,
    .rx_last,
    .match (ila_trigger)
  );

  frame_matcher #(.COMPARE(`SLOW_STRING)) u_slow_match (
    .CPUCLK,
    .bus_struct_reset,
    .rx_data,
    .rx_keep,
    .rx_valid,
    .rx_last,
    .match (slow_request)
  );

  //////////////////////////////////////////////////
  // slow-down control
  //////////////////////////////////////////////////

  request_tracker u_request_tracker (
    .CPUCLK,
    .bus_struct_reset,
    .slow_request,
    .stalling,
    .window_end,
    .request_pending
  );

  stall_sequencer u_stall_sequencer (
    .CPUCLK,
    .bus_struct_reset,
    .slow_request,
    .request_pending,
    .rvvi_stall,
    .stalling,
    .window_end,
    .host_stall
  );

  assign external_stall = rvvi_stall | host_stall;  // no added latency

endmodule

// File: hw/stall_sequencer.sv
// host stall window of STALL_CYCLES+1 cycles; waits in armed as long as rvvi_stall stays low
`timescale 1ns/1ps
`include "rvvi_host_config.svh"

module stall_sequencer import rvvi_host_pkg::*; (
  input  logic CPUCLK,
  input  logic bus_struct_reset,
  input  logic slow_request,
  input  logic request_pending,
  input  logic rvvi_stall,
  output logic stalling,
  output logic window_end,
  output logic host_stall
);

  slow_state_t  state;
  slow_state_t  state_next;
  stall_count_t stall_count;  // cycles spent stalling in this window
  logic         threshold;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      state <= slow_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      slow_idle: begin
        if (slow_request || request_pending) begin
          state_next = slow_armed;
        end
      end
      slow_armed: begin
        // start only once the packetizer is holding the core itself
        if (rvvi_stall) begin
          state_next = slow_stalling;
        end
      end
      slow_stalling: begin
        if (threshold) begin
          state_next = slow_idle;
        end
      end
      default: state_next = slow_idle;
    endcase
  end

  //////////////////////////////////////////////////
  // window length
  //////////////////////////////////////////////////

  // cleared in idle, holds at zero through armed
  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      stall_count <= '0;
    end else if (state == slow_idle) begin
      stall_count <= '0;
    end else if (stalling) begin
      stall_count <= stall_count + 1'b1;
    end
  end

  assign threshold  = (stall_count >= stall_count_t'(`STALL_CYCLES));
  assign stalling   = (state == slow_stalling);
  assign window_end = stalling & threshold;  // last cycle of the window

  // registered from the next state so it lines up with the stalling state
  always_ff @(posedge CPUCLK) begin
    if (bus_struct_reset) begin
      host_stall <= 1'b0;
    end else begin
      host_stall <= (state_next == slow_stalling);
    end
  end

endmodule

// File: include/rvvi_host_config.svh
// host-control constants; strings are fixed at build time, word 0 of a frame sits in bits 31:0
`ifndef RVVI_HOST_CONFIG_SVH
`define RVVI_HOST_CONFIG_SVH

//////////////////////////////////////////////////
// receive stream
//////////////////////////////////////////////////

`define RX_WORD_W     32  // mac receive data width
`define RX_KEEP_W     4   // one keep bit per byte
`define FRAME_WORDS   5   // header words compared per frame

//////////////////////////////////////////////////
// slow-down window
//////////////////////////////////////////////////

`define STALL_CYCLES  2000  // window closes when the counter reaches this
`define STALL_CNT_W   17
`define PENDING_CNT_W 10    // requests queued behind the current window

//////////////////////////////////////////////////
// compare strings, least significant word first
//////////////////////////////////////////////////

// words from low to high: dst mac [31:0], dst mac [47:32] with src mac [15:0],
// src mac [47:16], ether type 005c with the first payload bytes, payload tail
// "trigin" payload
`define TRIGGER_STRING \
  160'h6e69_6769_7274_005c_8f54_0000_1654_4502_1111_6843

// "slowme" payload, same addressing as the trigger frame
`define SLOW_STRING \
  160'h656d_776f_6c73_005c_8f54_0000_1654_4502_1111_6843

`endif

// File: rvvi_host_top.f
+incdir+include
hw/rvvi_host_pkg.sv
hw/frame_matcher.sv
hw/request_tracker.sv
hw/stall_sequencer.sv
hw/rvvi_host_top.sv
test/rvvi_host_assertions.sv
test/rvvi_host_tb.sv

// File: test/rvvi_host_assertions.sv
// output timing rules only; inputs are judged as sampled on the rising CPUCLK edge
`timescale 1ns/1ps

module rvvi_host_assertions (
  input logic CPUCLK,
  input logic bus_struct_reset,
  input logic rvvi_stall,
  input logic ila_trigger,
  input logic host_stall,
  input logic external_stall
);

  int assert_fails = 0;  // picked up by the testbench at the end of the run

  //////////////////////////////////////////////////
  // trigger and stall rules
  //////////////////////////////////////////////////

  // one pulse per matching frame
  a_trigger_single : assert property (@(posedge CPUCLK) disable iff (bus_struct_reset)
    ila_trigger |=> !ila_trigger)
  else begin
    $error("ila_trigger stayed high for two cycles");
    assert_fails++;
  end

  a_stall_covered : assert property (@(posedge CPUCLK) disable iff (bus_struct_reset)
    host_stall |-> external_stall)
  else begin
    $error("host_stall high without external_stall");
    assert_fails++;
  end

  // window opens only behind a packetizer stall
  a_stall_after_packetizer : assert property (@(posedge CPUCLK) disable iff (bus_struct_reset)
    $rose(host_stall) |-> $past(rvvi_stall))
  else begin
    $error("host_stall rose while rvvi_stall was low the cycle before");
    assert_fails++;
  end

endmodule

bind rvvi_host_top rvvi_host_assertions u_assertions (.*);

// File: test/rvvi_host_tb.sv
// slow rows run a few thousand cycles each since one window is STALL_CYCLES+1 cycles long
`timescale 1ns/1ps
`include "rvvi_host_config.svh"

module rvvi_host_tb;

  localparam int FRAME_BITS = `FRAME_WORDS * `RX_WORD_W;
  localparam logic [FRAME_BITS-1:0] TRIG_STR = `TRIGGER_STRING;
  localparam logic [FRAME_BITS-1:0] SLOW_STR = `SLOW_STRING;
  localparam int STALL_LEN = `STALL_CYCLES + 1;  // count runs 0 .. STALL_CYCLES
  localparam int QUIET = 100;                    // low host_stall cycles that close a row
  localparam logic [31:0] SEED = 32'h5a17_0091;

  // frame kinds
  localparam int K_TRIG = 0;
  localparam int K_SLOW = 1;
  localparam int K_CORRUPT = 2;  // trigger with word 3 flipped
  localparam int K_KEEP = 3;     // trigger with a keep bit cleared in word 2
  localparam int K_SHORT = 4;    // trigger header cut short
  // rvvi_stall modes
  localparam int S_LOW = 0;      // stays low
  localparam int S_HIGH = 1;     // high before the frame
  localparam int S_LATE = 2;     // raised after a random wait

  typedef struct packed {
    int kind;
    int len;
    int nframes;   // frames sent back to back
    int stall;
    int resend;    // second slow frame inside the window
    int exp_trig;
    int exp_win;
  } row_t;

  logic                  CPUCLK = 1'b0;
  logic                  bus_struct_reset;
  logic [`RX_WORD_W-1:0] rx_data;
  logic [`RX_KEEP_W-1:0] rx_keep;
  logic                  rx_valid;
  logic                  rx_last;
  logic                  rvvi_stall;
  logic                  ila_trigger;
  logic                  host_stall;
  logic                  external_stall;

  row_t  rows[$];
  string names[$];
  string cur_name = "none";
  int    checks = 0;
  int    errors = 0;
  int    trig_seen = 0;
  int    windows_seen = 0;
  int    run_len = 0;
  logic  stall_prev = 1'b0;
  logic  monitor_on = 1'b0;

  always #4 CPUCLK = ~CPUCLK;  // 8 ns period

  rvvi_host_top u_dut (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %s %s: expected %0d, actual %0d", cur_name, what, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input int kind, input int len, input int nframes,
                         input int stall, input int resend, input int exp_trig,
                         input int exp_win);
    names.push_back(name);
    rows.push_back('{kind, len, nframes, stall, resend, exp_trig, exp_win});
  endtask

  function automatic logic [31:0] frame_word(input int kind, input int idx);
    logic [FRAME_BITS-1:0] str;
    logic [31:0]           w;
    str = (kind == K_SLOW) ? SLOW_STR : TRIG_STR;
    if (idx >= `FRAME_WORDS) begin
      return $urandom;  // payload filler
    end
    w = str[idx*`RX_WORD_W +: `RX_WORD_W];
    if (kind == K_CORRUPT && idx == 3) begin
      w = w ^ 32'h0000_0100;
    end
    return w;
  endfunction

  // words go out at falling edges, pulse checked one cycle after the last word
  task automatic send_frames(input int kind, input int len, input int nframes);
    for (int f = 0; f < nframes; f++) begin
      for (int i = 0; i < len; i++) begin
        @(negedge CPUCLK);
        rx_valid = 1'b1;
        rx_data  = frame_word(kind, i);
        rx_keep  = (kind == K_KEEP && i == 2) ? 4'b0111 : 4'b1111;
        rx_last  = (i == len - 1);
      end
    end
    @(negedge CPUCLK);
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    rx_data  = '0;
    rx_keep  = '0;
    #1;
    check("trigger pulse", (kind == K_TRIG), ila_trigger);
  endtask

  task automatic wait_host_stall(input int limit, output int cycles);
    cycles = 0;
    while (!host_stall && cycles < limit) begin
      @(negedge CPUCLK);
      #1;
      cycles++;
    end
    if (!host_stall) begin
      errors++;
      $display("timeout: host_stall did not rise within %0d cycles in %s", limit, cur_name);
    end
  endtask

  // ends once host_stall has stayed low for QUIET cycles
  task automatic wait_quiet(input int limit);
    int quiet;
    int cycles;
    quiet = 0;
    cycles = 0;
    while (quiet < QUIET && cycles < limit) begin
      @(negedge CPUCLK);
      #1;
      cycles++;
      quiet = host_stall ? 0 : quiet + 1;
    end
    if (quiet < QUIET) begin
      errors++;
      $display("timeout: host_stall never settled low within %0d cycles in %s", limit, cur_name);
    end
  endtask

  //////////////////////////////////////////////////
  // output monitor
  //////////////////////////////////////////////////

  always begin
    @(negedge CPUCLK);
    #1;  // inputs changed at the falling edge, all settled here
    if (monitor_on) begin
      check("external_stall", rvvi_stall | host_stall, external_stall);
      if (ila_trigger) trig_seen++;
      if (host_stall && !stall_prev) windows_seen++;
      if (host_stall) begin
        run_len++;
      end else if (stall_prev) begin
        check("window length", STALL_LEN, run_len);
        run_len = 0;
      end
      stall_prev = host_stall;
    end
  end

  //////////////////////////////////////////////////
  // stimulus table and main sequence
  //////////////////////////////////////////////////

  initial begin
    row_t r;
    int   lat;
    int   gap;
    int   trig_base;
    int   win_base;
    int   afails;
    void'($urandom(SEED));
    bus_struct_reset = 1'b1;
    rx_data          = '0;
    rx_keep          = '0;
    rx_valid         = 1'b0;
    rx_last          = 1'b0;
    rvvi_stall       = 1'b0;

    //      name               kind       len frames stall   resend trig win
    add_row("trigger_frame",   K_TRIG,    5,  1,     S_LOW,  0,     1,   0);
    add_row("trigger_long",    K_TRIG,    9,  1,     S_LOW,  0,     1,   0);
    add_row("trigger_b2b",     K_TRIG,    6,  3,     S_LOW,  0,     3,   0);
    add_row("trigger_corrupt", K_CORRUPT, 7,  1,     S_LOW,  0,     0,   0);
    add_row("trigger_keep",    K_KEEP,    5,  1,     S_LOW,  0,     0,   0);
    add_row("short_frame",     K_SHORT,   3,  1,     S_LOW,  0,     0,   0);
    add_row("slow_stall_high", K_SLOW,    6,  1,     S_HIGH, 0,     0,   1);
    add_row("slow_stall_late", K_SLOW,    5,  1,     S_LATE, 0,     0,   1);
    add_row("slow_twice",      K_SLOW,    5,  1,     S_HIGH, 1,     0,   2);

    repeat (2) @(negedge CPUCLK);
    bus_struct_reset = 1'b0;
    #1;
    cur_name = "after_reset";
    check("ila_trigger", 0, ila_trigger);
    check("host_stall", 0, host_stall);
    check("external_stall", 0, external_stall);
    monitor_on = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      r         = rows[i];
      cur_name  = names[i];
      trig_base = trig_seen;
      win_base  = windows_seen;
      if (r.stall == S_HIGH) begin
        @(negedge CPUCLK);
        rvvi_stall = 1'b1;
      end
      send_frames(r.kind, r.len, r.nframes);
      if (r.stall == S_HIGH) begin
        wait_host_stall(20, lat);
        check("arm latency", 2, lat);  // match, armed, then stalling
      end else if (r.stall == S_LATE) begin
        gap = 20 + $urandom % 200;
        repeat (gap) begin
          @(negedge CPUCLK);
          #1;
          check("held while armed", 0, host_stall);
        end
        @(negedge CPUCLK);
        rvvi_stall = 1'b1;
        #1;
        wait_host_stall(20, lat);
        check("start latency", 1, lat);
        @(negedge CPUCLK);
        rvvi_stall = 1'b0;  // window runs on with only the host holding the core
        #1;
        check("external_stall in window", 1, external_stall);
      end
      if (r.resend != 0) begin
        gap = 10 + $urandom % 1000;  // well inside the window
        repeat (gap) @(negedge CPUCLK);
        send_frames(K_SLOW, r.len, 1);
      end
      wait_quiet(3 * STALL_LEN + 500);
      check("trigger count", r.exp_trig, trig_seen - trig_base);
      check("window count", r.exp_win, windows_seen - win_base);
      @(negedge CPUCLK);
      rvvi_stall = 1'b0;
      repeat (1 + $urandom % 8) @(negedge CPUCLK);  // idle gap between rows
    end

    afails = u_dut.u_assertions.assert_fails;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
    if (errors == 0 && afails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
